// ==== src/neuron_pkg.sv ====
package neuron_pkg;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Word types
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	typedef logic [31:0] word_t;
	typedef logic [3:0]  idx_t;
	typedef logic [7:0]  exp_t;

	// Mantissa with the hidden bit in front
	typedef logic [23:0] mant_t;

	localparam int N_INPUTS = 15;

	// Largest finite magnitude, used when an exponent overflows
	localparam logic [30:0] MAX_MAG = 31'h7F7F_FFFF;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Node constants
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	localparam word_t BIAS = 32'h3DAE_CA6E;

	localparam word_t WEIGHTS [N_INPUTS] = '{
		32'hBF1F_E2C5, 32'hBE55_58B1, 32'hBE7E_81FA, 32'hBED3_1F6C,
		32'h3DBD_7AF0, 32'hBF9E_0BE0, 32'h3EAB_364D, 32'hBF23_42B6,
		32'hBC34_9AD5, 32'hBDA4_3BF4, 32'h3F68_5DAB, 32'hBDDF_50A0,
		32'hBDBF_6FC3, 32'h3EB3_8BE5, 32'h3E0C_D576
	};

	typedef enum logic [1:0] {
		IDLE,
		ISSUE,
		DRAIN
	} ctrl_state_t;

endpackage

// ==== src/neuron_if.sv ====
interface mac_if;

	// Issue side, one index per cycle
	logic issue;
	neuron_pkg::idx_t idx;
	logic last;

	// Seeds the accumulator with the bias
	logic clear;

	// One-cycle pulse when the rectified result is in y
	logic done;

	modport ctrl (
		output issue,
		output idx,
		output last,
		output clear,
		input  done
	);

	modport bank (
		input issue,
		input idx,
		input last
	);

	modport acc (
		input  clear,
		output done
	);

endinterface

// ==== src/operand_bank.sv ====
module operand_bank (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              x_we,
	input  neuron_pkg::idx_t  x_addr,
	input  neuron_pkg::word_t x_data,
	input  logic              busy,
	mac_if.bank               m,
	output neuron_pkg::word_t a,
	output neuron_pkg::word_t b,
	output logic              pair_valid,
	output logic              pair_last
);

	neuron_pkg::word_t mem [neuron_pkg::N_INPUTS];
	logic wr_ok;

	// Writes only land while idle, addresses past the last input are dropped
	assign wr_ok = x_we && !busy && (x_addr < neuron_pkg::N_INPUTS);

	always_ff @(posedge clk)
	begin
		if (wr_ok)
		begin
			mem[x_addr] <= x_data;
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Registered read port
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_ff @(posedge clk)
	begin
		if (m.issue)
		begin
			a <= mem[m.idx];
			b <= neuron_pkg::WEIGHTS[m.idx];
		end
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			pair_valid <= 1'b0;
			pair_last  <= 1'b0;
		end
		else
		begin
			pair_valid <= m.issue;
			pair_last  <= m.issue && m.last;
		end
	end

endmodule

// ==== src/fp_mult.sv ====
module fp_mult (
	input  logic              clk,
	input  logic              rst_n,
	input  neuron_pkg::word_t a,
	input  neuron_pkg::word_t b,
	input  logic              in_valid,
	input  logic              in_last,
	output neuron_pkg::word_t p,
	output logic              out_valid,
	output logic              out_last
);

	neuron_pkg::exp_t  ea;
	neuron_pkg::exp_t  eb;
	neuron_pkg::mant_t ma;
	neuron_pkg::mant_t mb;
	neuron_pkg::word_t p_next;
	logic              sign;
	logic              zero_in;
	logic [47:0]       prod;
	logic [9:0]        exp_n;
	logic [22:0]       frac;

	assign ea = a[30:23];
	assign eb = b[30:23];
	assign sign = a[31] ^ b[31];

	// Zero and subnormal operands both count as zero
	assign zero_in = (ea == 8'd0) || (eb == 8'd0);

	assign ma = {1'b1, a[22:0]};
	assign mb = {1'b1, b[22:0]};
	assign prod = ma * mb;

	// The product lies in [1, 4), so at most one position of normalization
	assign frac = prod[47] ? prod[46:24] : prod[45:23];

	// Bit 9 set means the biased exponent went negative
	assign exp_n = {2'b00, ea} + {2'b00, eb} + {9'd0, prod[47]} - 10'd127;

	always_comb
	begin
		if (zero_in || exp_n[9] || exp_n == 10'd0)
			p_next = '0;
		else if (exp_n >= 10'd255)
			p_next = {sign, neuron_pkg::MAX_MAG};
		else
			p_next = {sign, exp_n[7:0], frac};
	end

	always_ff @(posedge clk)
	begin
		p <= p_next;
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			out_valid <= 1'b0;
			out_last  <= 1'b0;
		end
		else
		begin
			out_valid <= in_valid;
			out_last  <= in_valid && in_last;
		end
	end

endmodule

// ==== src/fp_add.sv ====
module fp_add (
	input  neuron_pkg::word_t a,
	input  neuron_pkg::word_t b,
	output neuron_pkg::word_t s
);

	neuron_pkg::word_t a_f;
	neuron_pkg::word_t b_f;
	neuron_pkg::word_t big;
	neuron_pkg::word_t lesser;
	neuron_pkg::exp_t  e_big;
	neuron_pkg::exp_t  e_small;
	neuron_pkg::exp_t  e_diff;
	neuron_pkg::mant_t m_big;
	neuron_pkg::mant_t m_small;
	neuron_pkg::mant_t m_shift;
	logic              eff_sub;
	logic              swap;
	logic [24:0]       raw;
	logic [4:0]        lz;
	logic [23:0]       m_norm;
	logic [8:0]        exp_up;
	logic [8:0]        exp_dn;

	function automatic logic [4:0] lzc24(input logic [23:0] v);
		logic [4:0] n;
		n = 5'd0;
		// The highest set bit is the last one to write n
		for (int i = 0; i < 24; i++)
		begin
			if (v[i])
				n = 5'(23 - i);
		end
		return n;
	endfunction

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Flush and order by magnitude
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	assign a_f = (a[30:23] == 8'd0) ? '0 : a;
	assign b_f = (b[30:23] == 8'd0) ? '0 : b;

	assign swap   = b_f[30:0] > a_f[30:0];
	assign big    = swap ? b_f : a_f;
	assign lesser = swap ? a_f : b_f;

	assign e_big   = big[30:23];
	assign e_small = lesser[30:23];
	assign e_diff  = e_big - e_small;

	assign m_big   = {e_big != 8'd0, big[22:0]};
	assign m_small = {e_small != 8'd0, lesser[22:0]};

	// Bits shifted out below the mantissa are lost, which truncates
	assign m_shift = m_small >> e_diff;

	assign eff_sub = big[31] ^ lesser[31];
	assign raw = eff_sub ? ({1'b0, m_big} - {1'b0, m_shift})
	                     : ({1'b0, m_big} + {1'b0, m_shift});

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Normalize
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	assign lz     = lzc24(raw[23:0]);
	assign m_norm = raw[23:0] << lz;
	assign exp_up = {1'b0, e_big} + 9'd1;
	assign exp_dn = {1'b0, e_big} - {4'd0, lz};

	always_comb
	begin
		if (raw == 25'd0)
		begin
			// Exact cancellation or two zeros
			s = '0;
		end
		else if (raw[24])
		begin
			if (exp_up >= 9'd255)
				s = {big[31], neuron_pkg::MAX_MAG};
			else
				s = {big[31], exp_up[7:0], raw[23:1]};
		end
		else if ({3'b000, lz} >= e_big)
		begin
			s = '0;
		end
		else
		begin
			s = {big[31], exp_dn[7:0], m_norm[22:0]};
		end
	end

endmodule

// ==== src/neuron_acc.sv ====
module neuron_acc (
	input  logic              clk,
	input  logic              rst_n,
	input  neuron_pkg::word_t p,
	input  logic              p_valid,
	input  logic              p_last,
	mac_if.acc                m,
	output neuron_pkg::word_t y
);

	neuron_pkg::word_t acc;
	neuron_pkg::word_t sum;
	logic              fin;

	fp_add add_i (
		.a(acc),
		.b(p),
		.s(sum)
	);

	assign fin = p_valid && p_last;

	always_ff @(posedge clk)
	begin
		if (m.clear)
			acc <= neuron_pkg::BIAS;
		else if (p_valid)
			acc <= sum;
	end

	// Rectifier on the final sum, negative zero included
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			y      <= '0;
			m.done <= 1'b0;
		end
		else
		begin
			m.done <= fin;
			if (fin)
				y <= sum[31] ? '0 : sum;
		end
	end

endmodule

// ==== src/neuron_ctrl.sv ====
module neuron_ctrl (
	input  logic clk,
	input  logic rst_n,
	input  logic start,
	output logic busy,
	mac_if.ctrl  m
);

	localparam neuron_pkg::idx_t LAST_IDX = neuron_pkg::idx_t'(neuron_pkg::N_INPUTS - 1);

	neuron_pkg::ctrl_state_t state;
	neuron_pkg::idx_t        cnt;
	logic                    accept;

	// The cycle with done high already counts as idle
	assign accept = (state == neuron_pkg::IDLE) || (state == neuron_pkg::DRAIN && m.done);
	assign busy = !accept;

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			state   <= neuron_pkg::IDLE;
			cnt     <= '0;
			m.issue <= 1'b0;
			m.idx   <= '0;
			m.last  <= 1'b0;
			m.clear <= 1'b0;
		end
		else
		begin
			m.issue <= 1'b0;
			m.last  <= 1'b0;
			m.clear <= 1'b0;
			case (state)
				neuron_pkg::ISSUE:
				begin
					m.issue <= 1'b1;
					m.idx   <= cnt;
					m.last  <= (cnt == LAST_IDX);
					cnt     <= cnt + 4'd1;
					if (cnt == LAST_IDX)
						state <= neuron_pkg::DRAIN;
				end
				default:
				begin
					// IDLE, or DRAIN in the cycle the result appears
					if (accept)
					begin
						if (start)
						begin
							state   <= neuron_pkg::ISSUE;
							cnt     <= '0;
							m.clear <= 1'b1;
						end
						else
						begin
							state <= neuron_pkg::IDLE;
						end
					end
				end
			endcase
		end
	end

endmodule

// ==== src/neuron_top.sv ====
module neuron_top (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              x_we,
	input  neuron_pkg::idx_t  x_addr,
	input  neuron_pkg::word_t x_data,
	input  logic              start,
	output logic              busy,
	output logic              done,
	output neuron_pkg::word_t y
);

	neuron_pkg::word_t a;
	neuron_pkg::word_t b;
	neuron_pkg::word_t p;
	logic              pair_valid;
	logic              pair_last;
	logic              p_valid;
	logic              p_last;

	mac_if mac ();

	neuron_ctrl ctrl_i (
		.clk  (clk),
		.rst_n(rst_n),
		.start(start),
		.busy (busy),
		.m    (mac)
	);

	operand_bank bank_i (
		.clk       (clk),
		.rst_n     (rst_n),
		.x_we      (x_we),
		.x_addr    (x_addr),
		.x_data    (x_data),
		.busy      (busy),
		.m         (mac),
		.a         (a),
		.b         (b),
		.pair_valid(pair_valid),
		.pair_last (pair_last)
	);

	fp_mult mult_i (
		.clk      (clk),
		.rst_n    (rst_n),
		.a        (a),
		.b        (b),
		.in_valid (pair_valid),
		.in_last  (pair_last),
		.p        (p),
		.out_valid(p_valid),
		.out_last (p_last)
	);

	neuron_acc acc_i (
		.clk    (clk),
		.rst_n  (rst_n),
		.p      (p),
		.p_valid(p_valid),
		.p_last (p_last),
		.m      (mac),
		.y      (y)
	);

	assign done = mac.done;

endmodule

// ==== test/neuron_clk_gen.sv ====
module neuron_clk_gen (
	output logic clk,
	output logic rst_n
);

	initial
	begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// Three rising edges pass with reset low, release lands on a falling edge
	initial
	begin
		rst_n = 1'b0;
		repeat (3) @(negedge clk);
		rst_n = 1'b1;
	end

endmodule

// ==== test/neuron_assertions.sv ====
module neuron_assertions (
	input logic                    clk,
	input logic                    rst_n,
	input logic                    start,
	input logic                    busy,
	input logic                    issue,
	input logic                    done,
	input neuron_pkg::ctrl_state_t state
);

	issue_only_in_issue: assert property (
		@(posedge clk) disable iff (!rst_n)
		$rose(issue) |-> state == neuron_pkg::ISSUE
	)
	else
		$error("issue rose outside the ISSUE state");

	// An accepted start is followed by done after exactly 18 cycles
	done_latency: assert property (
		@(posedge clk) disable iff (!rst_n)
		(start && !busy) |=> (!done) [*18] ##1 done
	)
	else
		$error("done did not follow an accepted start after 18 cycles");

	busy_low_on_done: assert property (
		@(posedge clk) disable iff (!rst_n)
		done |-> !busy
	)
	else
		$error("busy was high while done was high");

endmodule

bind neuron_ctrl neuron_assertions asrt_i (
	.clk  (clk),
	.rst_n(rst_n),
	.start(start),
	.busy (busy),
	.issue(m.issue),
	.done (m.done),
	.state(state)
);

// ==== test/neuron_tb.sv ====
module neuron_tb;

	logic              clk;
	logic              rst_n;
	logic              x_we;
	neuron_pkg::idx_t  x_addr;
	neuron_pkg::word_t x_data;
	logic              start;
	logic              busy;
	logic              done;
	neuron_pkg::word_t y;

	neuron_pkg::word_t x [neuron_pkg::N_INPUTS];
	neuron_pkg::word_t exp_y;
	int                kind;
	int                n_vec;
	int                seed;

	neuron_clk_gen clk_gen_i (
		.clk  (clk),
		.rst_n(rst_n)
	);

	neuron_top dut_i (
		.clk   (clk),
		.rst_n (rst_n),
		.x_we  (x_we),
		.x_addr(x_addr),
		.x_data(x_data),
		.start (start),
		.busy  (busy),
		.done  (done),
		.y     (y)
	);

	task automatic stop_on_error(input string why);
		$display("%s", why);
		$display("TEST FAIL");
		$fatal(1);
	endtask

	task automatic check_word(input string name, input neuron_pkg::word_t actual,
	                          input neuron_pkg::word_t expected);
		assert (actual === expected)
		else
			stop_on_error($sformatf("FAILED time %0t %s expected %h actual %h",
			                        $time, name, expected, actual));
	endtask

	task automatic load_inputs();
		for (int i = 0; i < neuron_pkg::N_INPUTS; i++)
		begin
			@(negedge clk);
			x_we   = 1'b1;
			x_addr = neuron_pkg::idx_t'(i);
			x_data = x[i];
		end
		@(negedge clk);
		x_we = 1'b0;
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// One computation from start to done
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	task automatic run_once(input bit disturb);
		int n;
		n = 0;
		@(negedge clk);
		start = 1'b1;
		@(negedge clk);
		start = 1'b0;
		while (!done && n < 40)
		begin
			check_word("busy", {31'd0, busy}, 32'd1);
			// A write and a second start in the middle of the run must both be dropped
			if (disturb && n == 3)
			begin
				x_we   = 1'b1;
				x_addr = neuron_pkg::idx_t'($random(seed));
				x_data = $random(seed);
				start  = 1'b1;
			end
			else
			begin
				x_we  = 1'b0;
				start = 1'b0;
			end
			@(negedge clk);
			n++;
		end
		if (!done)
			stop_on_error("Timeout: done did not arrive within 40 cycles of start");
		check_word("done latency", n, 32'd18);
		check_word("busy", {31'd0, busy}, 32'd0);
		@(negedge clk);
		check_word("done", {31'd0, done}, 32'd0);
	endtask

	task automatic run_vector();
		load_inputs();
		run_once(1'b1);
		check_word("y", y, exp_y);
		if (kind == 0)
			check_word("y", y, neuron_pkg::BIAS);
		if (kind == 2)
			check_word("y", y, 32'd0);
		run_once(1'b0);
		check_word("y", y, exp_y);
		n_vec++;
	endtask

	initial
	begin
		int    n;
		int    fd;
		int    cnt;
		string line;
		seed   = 28703;
		x_we   = 1'b0;
		x_addr = '0;
		x_data = '0;
		start  = 1'b0;
		n_vec  = 0;
		n      = 0;
		while (rst_n !== 1'b1 && n < 10)
		begin
			@(negedge clk);
			n++;
		end
		if (rst_n !== 1'b1)
			stop_on_error("Reset was never released");
		check_word("busy", {31'd0, busy}, 32'd0);
		check_word("done", {31'd0, done}, 32'd0);
		check_word("issue", {31'd0, dut_i.mac.issue}, 32'd0);
		check_word("y", y, 32'd0);

		fd = $fopen("test/neuron_trace.txt", "r");
		if (fd == 0)
			stop_on_error("Could not open test/neuron_trace.txt");
		while (!$feof(fd))
		begin
			line = "";
			void'($fgets(line, fd));
			if (line.len() > 1 && line[0] != "#")
			begin
				cnt = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
				              kind, x[0], x[1], x[2], x[3], x[4], x[5], x[6], x[7],
				              x[8], x[9], x[10], x[11], x[12], x[13], x[14], exp_y);
				if (cnt != 17)
					stop_on_error("A line of the trace file has the wrong number of fields");
				run_vector();
			end
		end
		$fclose(fd);

		if (n_vec == 0)
		begin
			$display("No vectors were read from the trace file");
			$display("TEST FAIL");
			$fatal(1);
		end
		else
		begin
			$display("TEST PASS");
			$finish;
		end
	end

endmodule

// ==== files.f ====
src/neuron_pkg.sv
src/neuron_if.sv
src/operand_bank.sv
src/fp_mult.sv
src/fp_add.sv
src/neuron_acc.sv
src/neuron_ctrl.sv
src/neuron_top.sv
test/neuron_clk_gen.sv
test/neuron_assertions.sv
test/neuron_tb.sv

// ==== Bender.yml ====
package:
  name: neuron

sources:
  - src/neuron_pkg.sv
  - src/neuron_if.sv
  - src/operand_bank.sv
  - src/fp_mult.sv
  - src/fp_add.sv
  - src/neuron_acc.sv
  - src/neuron_ctrl.sv
  - src/neuron_top.sv
  - target: test
    files:
      - test/neuron_clk_gen.sv
      - test/neuron_assertions.sv
      - test/neuron_tb.sv

// ==== test/neuron_trace.txt ====
# kind x0 x1 x2 x3 x4 x5 x6 x7 x8 x9 x10 x11 x12 x13 x14 y, all fields in hex
# kind 0 is the all-zero vector, 1 a positive sum, 2 a negative sum
0 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 3DAECA6E
1 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 3F800000 00000000 00000000 00000000 00000000 3F7E36F8
1 3F800000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 3F800000 00000000 00000000 00000000 00000000 3EBCA866
1 00000000 00000000 00000000 00000000 00000000 00000000 3F800000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 3ED6E8E8
1 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 3FC00000 00000000 00000000 00000000 00000000 3FB932E6
1 00000000 00000000 00000000 00000000 00000000 00000000 3F800000 00000000 00000000 00000000 3FC00000 00000000 00000000 00000000 00000000 3FE4007A
1 00000000 00000000 00000000 BF800000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 3EFED207
1 00000000 00000000 00000000 BF800000 00000000 00000000 00000000 00000000 00000000 00000000 3F800000 00000000 00000000 00000000 00000000 3FB3E357
1 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00400000 00000000 00000000 00000000 00000000 3DAECA6E
1 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00800000 00000000 00000000 00000000 00000000 3DAECA6E
2 00000000 00000000 00000000 00000000 00000000 3F800000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000
2 40000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000
2 00000000 00000000 00000000 00000000 00000000 3F800000 00000000 00000000 00000000 00000000 3F800000 00000000 00000000 00000000 00000000 00000000
